// ==== hdl/dualIssuePkg.sv ====
`default_nettype none

package dualIssuePkg;

    localparam int XLEN        = 32;
    localparam int REG_COUNT   = 32;
    localparam int INST_BYTES  = 4;
    localparam int PAIR_BYTES  = 2 * INST_BYTES;   // master + slave word
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [XLEN-1:0]        word_t;
    typedef logic [XLEN-1:0]        addr_t;
    typedef logic [31:0]            inst_t;
    typedef logic [4:0]             regIdx_t;
    typedef logic [5:0]             opField_t;     // opcode and funct fields
    typedef logic [QUEUE_PTR_W-1:0] qPtr_t;
    typedef logic [QUEUE_PTR_W:0]   qCount_t;      // one extra bit to hold "full"

    localparam addr_t RESET_PC = 32'hBFC0_0000;    // boot vector

    // major opcodes
    localparam opField_t OPC_RTYPE = 6'h00;
    localparam opField_t OPC_ADDIU = 6'h09;
    localparam opField_t OPC_ORI   = 6'h0D;

    // SPECIAL funct codes
    localparam opField_t FN_ADDU = 6'h21;
    localparam opField_t FN_SUBU = 6'h23;
    localparam opField_t FN_AND  = 6'h24;
    localparam opField_t FN_OR   = 6'h25;
    localparam opField_t FN_XOR  = 6'h26;
    localparam opField_t FN_SLT  = 6'h2A;

    typedef struct packed {
        addr_t pc;      // address of inst1
        inst_t inst1;
        inst_t inst2;
    } fetchPair_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOp_e;

    typedef struct packed {
        logic    valid;
        addr_t   pc;
        aluOp_e  aluOp;
        logic    regWrite;
        regIdx_t rd;
        word_t   opA;
        word_t   opB;   // rt value or extended immediate
    } issue_t;

    typedef struct packed {
        logic    valid;
        addr_t   pc;
        logic    regWrite;
        regIdx_t wnum;
        word_t   wdata;
    } commit_t;

    typedef enum logic {
        ISSUE_PAIR,     // both halves of the head pair still pending
        ISSUE_SLAVE     // master gone, slave waits for forwarding
    } issueState_e;

endpackage

`default_nettype wire

// ==== hdl/executeLane.sv ====
`default_nettype none

module executeLane
    import dualIssuePkg::*;
(
    input  wire             clk,
    input  wire             rst_i,
    input  wire issue_t     issue_i,
    output commit_t         commit_o
);

    word_t aluResult;
    logic  lessThan;

    assign lessThan = $signed(issue_i.opA) < $signed(issue_i.opB);

    always_comb begin
        case (issue_i.aluOp)
            ALU_ADD: aluResult = issue_i.opA + issue_i.opB;
            ALU_SUB: aluResult = issue_i.opA - issue_i.opB;
            ALU_AND: aluResult = issue_i.opA & issue_i.opB;
            ALU_OR:  aluResult = issue_i.opA | issue_i.opB;
            ALU_XOR: aluResult = issue_i.opA ^ issue_i.opB;
            ALU_SLT: aluResult = {{(XLEN-1){1'b0}}, lessThan};
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            commit_o.valid    <= 1'b0;
            commit_o.regWrite <= 1'b0;
        end else begin
            commit_o.valid    <= issue_i.valid;
            // $zero writes retire but never land
            commit_o.regWrite <= issue_i.valid & issue_i.regWrite & (issue_i.rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        commit_o.pc    <= issue_i.pc;
        commit_o.wnum  <= issue_i.rd;
        commit_o.wdata <= aluResult;
    end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`default_nettype none

module regFile
    import dualIssuePkg::*;
(
    input  wire              clk,
    input  wire              rst_i,
    input  wire regIdx_t     raddr1_i,
    input  wire regIdx_t     raddr2_i,
    input  wire regIdx_t     raddr3_i,
    input  wire regIdx_t     raddr4_i,
    output word_t            rdata1_o,
    output word_t            rdata2_o,
    output word_t            rdata3_o,
    output word_t            rdata4_o,
    input  wire commit_t     wrMaster_i,
    input  wire commit_t     wrSlave_i
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wrMaster_i.valid && wrMaster_i.regWrite && wrMaster_i.wnum != '0) begin
                regs[wrMaster_i.wnum] <= wrMaster_i.wdata;
            end
            // later assignment wins, slave is younger
            if (wrSlave_i.valid && wrSlave_i.regWrite && wrSlave_i.wnum != '0) begin
                regs[wrSlave_i.wnum] <= wrSlave_i.wdata;
            end
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
    assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i];
    assign rdata4_o = (raddr4_i == '0) ? '0 : regs[raddr4_i];

endmodule

`default_nettype wire

// ==== hdl/fetchUnit.sv ====
`default_nettype none

module fetchUnit
    import dualIssuePkg::*;
(
    input  wire               clk,
    input  wire               rst_i,
    input  wire               icacheStall_i,
    input  wire inst_t        inst1_i,
    input  wire inst_t        inst2_i,
    input  wire               almostFull_i,
    output addr_t             pc_o,
    output logic              instEn_o,
    output logic              pushValid_o,
    output fetchPair_t        pushPair_o
);

    addr_t pcQ;
    logic  reqQ;        // request on the bus this cycle
    logic  respQ;       // pair expected back this cycle
    logic  respDone;
    logic  reqNext;

    assign respDone = respQ & ~icacheStall_i;

    // a stalled response asks again at once, otherwise wait for queue room
    assign reqNext = ~reqQ & ((respQ & icacheStall_i) | ~almostFull_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pcQ   <= RESET_PC;
            reqQ  <= 1'b0;
            respQ <= 1'b0;
        end else begin
            reqQ  <= reqNext;
            respQ <= reqQ;
            if (respDone) begin
                pcQ <= pcQ + addr_t'(PAIR_BYTES);
            end
        end
    end

    assign pc_o     = pcQ;
    assign instEn_o = reqQ;

    // pc only moves after the push, so it still tags this pair
    assign pushValid_o = respDone;
    assign pushPair_o  = '{pc: pcQ, inst1: inst1_i, inst2: inst2_i};

    // pairs are fetched on 8-byte boundaries
    pcAligned: assert property (@(posedge clk) disable iff (rst_i)
        pc_o[2:0] == 3'b000);

endmodule

`default_nettype wire

// ==== hdl/fetchQueue.sv ====
`default_nettype none

module fetchQueue
    import dualIssuePkg::*;
(
    input  wire                clk,
    input  wire                rst_i,
    input  wire                pushValid_i,
    input  wire fetchPair_t    pushPair_i,
    input  wire                pop_i,
    output logic               headValid_o,
    output fetchPair_t         headPair_o,
    output logic               almostFull_o
);

    fetchPair_t entries [QUEUE_DEPTH];
    qPtr_t      wrPtr;
    qPtr_t      rdPtr;
    qCount_t    count;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid_i) begin
                wrPtr <= wrPtr + 1'b1;  // depth is a power of two, wraps on its own
            end
            if (pop_i) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({pushValid_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (pushValid_i) begin
            entries[wrPtr] <= pushPair_i;
        end
    end

    assign headValid_o = (count != '0);
    assign headPair_o  = entries[rdPtr];

    // fewer than two free slots: one push may still be on its way
    assign almostFull_o = (count > qCount_t'(QUEUE_DEPTH - 2));

    noOverflow: assert property (@(posedge clk) disable iff (rst_i)
        pushValid_i |-> count != qCount_t'(QUEUE_DEPTH));

    noUnderflow: assert property (@(posedge clk) disable iff (rst_i)
        pop_i |-> count != '0);

endmodule

`default_nettype wire

// ==== hdl/issueUnit.sv ====
`default_nettype none

module issueUnit
    import dualIssuePkg::*;
(
    input  wire                clk,
    input  wire                rst_i,
    input  wire                headValid_i,
    input  wire fetchPair_t    headPair_i,
    output logic               pop_o,
    output commit_t            commitMaster_o,
    output commit_t            commitSlave_o
);

    issueState_e stateQ;
    issueState_e stateNext;
    inst_t       inst1;
    inst_t       inst2;
    word_t       mRsRf, mRtRf, sRsRf, sRtRf;    // raw register file reads
    word_t       mRs, mRt, sRs, sRt;            // after forwarding
    issue_t      masterDec;
    issue_t      slaveDec;
    issue_t      masterIssue;
    issue_t      slaveIssue;
    commit_t     commitMaster;
    commit_t     commitSlave;
    logic        slaveReadsRt;
    logic        slaveDepends;

    // last cycle's results beat the register file, slave is younger
    function automatic word_t forwardOperand(regIdx_t idx, word_t rfVal,
                                             commit_t cm, commit_t cs);
        word_t val;
        val = rfVal;
        if (cm.valid && cm.regWrite && cm.wnum == idx)
            val = cm.wdata;
        if (cs.valid && cs.regWrite && cs.wnum == idx)
            val = cs.wdata;
        return val;
    endfunction

    function automatic issue_t decodeInst(inst_t inst, addr_t pc, word_t rsVal, word_t rtVal);
        issue_t dec;
        dec       = '0;
        dec.pc    = pc;
        dec.aluOp = ALU_ADD;
        dec.rd    = inst[15:11];
        dec.opA   = rsVal;
        dec.opB   = rtVal;
        case (inst[31:26])
            OPC_RTYPE: begin
                dec.regWrite = 1'b1;
                case (inst[5:0])
                    FN_ADDU: dec.aluOp = ALU_ADD;
                    FN_SUBU: dec.aluOp = ALU_SUB;
                    FN_AND:  dec.aluOp = ALU_AND;
                    FN_OR:   dec.aluOp = ALU_OR;
                    FN_XOR:  dec.aluOp = ALU_XOR;
                    FN_SLT:  dec.aluOp = ALU_SLT;
                    default: dec.regWrite = 1'b0;   // shifts, nop and the rest
                endcase
            end
            OPC_ADDIU: begin
                dec.regWrite = 1'b1;
                dec.rd       = inst[20:16];
                dec.opB      = {{16{inst[15]}}, inst[15:0]};
            end
            OPC_ORI: begin
                dec.regWrite = 1'b1;
                dec.aluOp    = ALU_OR;
                dec.rd       = inst[20:16];
                dec.opB      = {16'h0000, inst[15:0]};
            end
            default: dec.regWrite = 1'b0;
        endcase
        return dec;
    endfunction

    assign inst1 = headPair_i.inst1;
    assign inst2 = headPair_i.inst2;

    assign mRs = forwardOperand(inst1[25:21], mRsRf, commitMaster, commitSlave);
    assign mRt = forwardOperand(inst1[20:16], mRtRf, commitMaster, commitSlave);
    assign sRs = forwardOperand(inst2[25:21], sRsRf, commitMaster, commitSlave);
    assign sRt = forwardOperand(inst2[20:16], sRtRf, commitMaster, commitSlave);

    assign masterDec = decodeInst(inst1, headPair_i.pc, mRs, mRt);
    assign slaveDec  = decodeInst(inst2, headPair_i.pc + addr_t'(INST_BYTES), sRs, sRt);

    // I-type slaves only read rs
    assign slaveReadsRt = (inst2[31:26] == OPC_RTYPE);
    assign slaveDepends = masterDec.regWrite && (masterDec.rd != '0) &&
                          ((inst2[25:21] == masterDec.rd) ||
                           (slaveReadsRt && inst2[20:16] == masterDec.rd));

    always_comb begin
        stateNext         = stateQ;
        masterIssue       = masterDec;
        masterIssue.valid = 1'b0;
        slaveIssue        = slaveDec;
        slaveIssue.valid  = 1'b0;
        pop_o             = 1'b0;
        if (headValid_i) begin
            if (stateQ == ISSUE_SLAVE) begin
                slaveIssue.valid = 1'b1;
                pop_o            = 1'b1;
                stateNext        = ISSUE_PAIR;
            end else if (slaveDepends) begin
                masterIssue.valid = 1'b1;   // split, slave goes next cycle
                stateNext         = ISSUE_SLAVE;
            end else begin
                masterIssue.valid = 1'b1;
                slaveIssue.valid  = 1'b1;
                pop_o             = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            stateQ <= ISSUE_PAIR;
        end else begin
            stateQ <= stateNext;
        end
    end

    regFile regFile_i (
        .clk       (clk),
        .rst_i     (rst_i),
        .raddr1_i  (inst1[25:21]),
        .raddr2_i  (inst1[20:16]),
        .raddr3_i  (inst2[25:21]),
        .raddr4_i  (inst2[20:16]),
        .rdata1_o  (mRsRf),
        .rdata2_o  (mRtRf),
        .rdata3_o  (sRsRf),
        .rdata4_o  (sRtRf),
        .wrMaster_i(commitMaster),
        .wrSlave_i (commitSlave)
    );

    executeLane masterLane (
        .clk     (clk),
        .rst_i   (rst_i),
        .issue_i (masterIssue),
        .commit_o(commitMaster)
    );

    executeLane slaveLane (
        .clk     (clk),
        .rst_i   (rst_i),
        .issue_i (slaveIssue),
        .commit_o(commitSlave)
    );

    assign commitMaster_o = commitMaster;
    assign commitSlave_o  = commitSlave;

    popNeedsHead: assert property (@(posedge clk) disable iff (rst_i)
        pop_o |-> headValid_i);

    // queue must keep the split pair at its head until the slave leaves
    splitHeadHeld: assert property (@(posedge clk) disable iff (rst_i)
        stateQ == ISSUE_SLAVE |-> headValid_i);

endmodule

`default_nettype wire

// ==== hdl/dualIssueCore.sv ====
`default_nettype none

module dualIssueCore
    import dualIssuePkg::*;
(
    input  wire             clk,
    input  wire             rst_i,
    input  wire             icacheStall_i,
    input  wire inst_t      inst1_i,
    input  wire inst_t      inst2_i,
    output addr_t           pc_o,
    output logic            instEn_o,
    output commit_t         commitMaster_o,
    output commit_t         commitSlave_o
);

    logic       pushValid;
    fetchPair_t pushPair;
    logic       almostFull;
    logic       headValid;
    fetchPair_t headPair;
    logic       pop;

    fetchUnit fetchUnit_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .icacheStall_i(icacheStall_i),
        .inst1_i      (inst1_i),
        .inst2_i      (inst2_i),
        .almostFull_i (almostFull),
        .pc_o         (pc_o),
        .instEn_o     (instEn_o),
        .pushValid_o  (pushValid),
        .pushPair_o   (pushPair)
    );

    fetchQueue fetchQueue_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .pushValid_i (pushValid),
        .pushPair_i  (pushPair),
        .pop_i       (pop),
        .headValid_o (headValid),
        .headPair_o  (headPair),
        .almostFull_o(almostFull)
    );

    issueUnit issueUnit_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .headValid_i   (headValid),
        .headPair_i    (headPair),
        .pop_o         (pop),
        .commitMaster_o(commitMaster_o),
        .commitSlave_o (commitSlave_o)
    );

endmodule

`default_nettype wire

// ==== test/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// columns: entry name, master word (inst1), slave word (inst2)
// rType(funct, rd, rs, rt) and iType(opcode, rt, rs, imm16)
task automatic loadProgram();
    addPair("imm_seed_a", iType(OPC_ADDIU, 1, 0, 16'hFFFB), iType(OPC_ORI, 2, 0, 16'h8001));
    addPair("imm_seed_b", iType(OPC_ADDIU, 3, 0, 16'h7FF0), iType(OPC_ADDIU, 4, 0, 16'h000C));
    addPair("fwd_add_sub", rType(FN_ADDU, 5, 1, 2), rType(FN_SUBU, 6, 3, 4));
    addPair("and_or", rType(FN_AND, 7, 2, 3), rType(FN_OR, 8, 1, 4));
    addPair("xor_slt", rType(FN_XOR, 9, 5, 6), rType(FN_SLT, 10, 1, 4));
    addPair("slt_neg", rType(FN_SLT, 11, 4, 1), rType(FN_SLT, 12, 1, 1));
    // slave depends on master through rs, then through rt
    addPair("split_rs", rType(FN_ADDU, 13, 5, 6), rType(FN_SUBU, 14, 13, 1));
    addPair("split_rt", iType(OPC_ORI, 15, 0, 16'h1234), rType(FN_XOR, 16, 2, 15));
    addPair("zero_write", iType(OPC_ADDIU, 0, 1, 16'h0007), rType(FN_ADDU, 17, 0, 3));
    addPair("zero_read", rType(FN_OR, 18, 0, 0), iType(OPC_ADDIU, 19, 0, 16'hFFFF));
    addPair("nop_master", 32'h0000_0000, rType(FN_ADDU, 20, 19, 19));
    addPair("split_chain", iType(OPC_ADDIU, 21, 20, 16'h0001),
            iType(OPC_ADDIU, 21, 21, 16'h0002));
    addPair("same_dest", rType(FN_ADDU, 22, 1, 2), rType(FN_ADDU, 22, 3, 4));
    addPair("unknown_op", rType(FN_SUBU, 23, 22, 0), 32'h8C22_0010);  // lw, retires as no-write
endtask

`endif

// ==== test/tbDualIssue.sv ====
`default_nettype none

module tbDualIssue
    import dualIssuePkg::*;
();

    localparam int MEM_PAIRS = 64;

    logic    clk;
    logic    rst_i;
    logic    icacheStall;
    inst_t   inst1;
    inst_t   inst2;
    addr_t   pc;
    logic    instEn;
    commit_t commitMaster;
    commit_t commitSlave;

    string progName [$];
    inst_t progInst1 [$];
    inst_t progInst2 [$];
    inst_t memLo [MEM_PAIRS];   // master words
    inst_t memHi [MEM_PAIRS];

    // expected retire stream in program order
    string   expName [$];
    addr_t   expPc [$];
    bit      expSlave [$];
    bit      expWrite [$];
    regIdx_t expNum [$];
    word_t   expData [$];
    bit      expSplit [$];      // slave of a dependent pair

    word_t  refRegs [REG_COUNT];
    int     expIdx = 0;
    int     valueErrors = 0;
    int     otherErrors = 0;
    int     cycles = 0;
    int     cycleLimit;
    integer seed = 31;

    dualIssueCore dualIssueCore_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .icacheStall_i (icacheStall),
        .inst1_i       (inst1),
        .inst2_i       (inst2),
        .pc_o          (pc),
        .instEn_o      (instEn),
        .commitMaster_o(commitMaster),
        .commitSlave_o (commitSlave)
    );

    function automatic inst_t rType(opField_t fn, regIdx_t rd, regIdx_t rs, regIdx_t rt);
        return {OPC_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic inst_t iType(opField_t opc, regIdx_t rt, regIdx_t rs, logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    task automatic addPair(input string name, input inst_t master, input inst_t slave);
        progName.push_back(name);
        progInst1.push_back(master);
        progInst2.push_back(slave);
    endtask

    `include "tbProgram.svh"

    // no-op outside the loaded range
    function automatic inst_t fetchWord(addr_t addr, bit slave);
        addr_t offset;
        inst_t word;
        word   = '0;
        offset = (addr - RESET_PC) >> 3;
        if (addr >= RESET_PC && offset < addr_t'(MEM_PAIRS)) begin
            word = slave ? memHi[offset] : memLo[offset];
        end
        return word;
    endfunction

    task automatic modelInst(input string name, input inst_t inst, input addr_t pcVal,
                             input bit slave, input bit split, output regIdx_t dest);
        word_t   a;
        word_t   b;
        word_t   res;
        regIdx_t wnum;
        bit      wr;
        a    = refRegs[inst[25:21]];
        b    = refRegs[inst[20:16]];
        res  = '0;
        wr   = 1'b1;
        wnum = inst[15:11];
        case (inst[31:26])
            OPC_RTYPE: begin
                case (inst[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            OPC_ADDIU: begin
                wnum = inst[20:16];
                res  = a + {{16{inst[15]}}, inst[15:0]};
            end
            OPC_ORI: begin
                wnum = inst[20:16];
                res  = a | {16'h0000, inst[15:0]};
            end
            default: wr = 1'b0;
        endcase
        if (wnum == '0)
            wr = 1'b0;              // $zero stays zero
        if (wr)
            refRegs[wnum] = res;
        expName.push_back(name);
        expPc.push_back(pcVal);
        expSlave.push_back(slave);
        expWrite.push_back(wr);
        expNum.push_back(wnum);
        expData.push_back(res);
        expSplit.push_back(split);
        dest = wr ? wnum : '0;
    endtask

    task automatic modelProgram();
        regIdx_t mDest;
        regIdx_t unused;
        regIdx_t sRs;
        regIdx_t sRt;
        bit      split;
        foreach (refRegs[k])
            refRegs[k] = '0;
        for (int i = 0; i < progName.size(); i++) begin
            modelInst(progName[i], progInst1[i], RESET_PC + addr_t'(i * PAIR_BYTES),
                      1'b0, 1'b0, mDest);
            sRs   = progInst2[i][25:21];
            sRt   = progInst2[i][20:16];
            split = 1'b0;
            if (mDest != '0) begin
                case (progInst2[i][31:26])
                    OPC_RTYPE:          split = (sRs == mDest) || (sRt == mDest);
                    OPC_ADDIU, OPC_ORI: split = (sRs == mDest);
                    default:            split = 1'b0;
                endcase
            end
            modelInst(progName[i], progInst2[i], RESET_PC + addr_t'(i * PAIR_BYTES + 4),
                      1'b1, split, unused);
        end
    endtask

    task automatic reportValue(input string name, input string field,
                               input logic [31:0] expVal, input logic [31:0] actVal);
        $display("CHECK FAILED %s %s: expected %h, actual %h", name, field, expVal, actVal);
        valueErrors++;
    endtask

    task automatic checkRetire(input commit_t c, input bit onSlave);
        string name;
        if (expIdx >= expName.size()) begin
            $display("extra commit at pc %h after the last table entry", c.pc);
            otherErrors++;
        end else begin
            name = expName[expIdx];
            if (c.pc !== expPc[expIdx])
                reportValue(name, "pc", expPc[expIdx], c.pc);
            if (onSlave !== expSlave[expIdx])
                reportValue(name, "slave port", 32'(expSlave[expIdx]), 32'(onSlave));
            if (c.regWrite !== expWrite[expIdx])
                reportValue(name, "regWrite", 32'(expWrite[expIdx]), 32'(c.regWrite));
            if (expWrite[expIdx] && c.wnum !== expNum[expIdx])
                reportValue(name, "wnum", 32'(expNum[expIdx]), 32'(c.wnum));
            if (expWrite[expIdx] && c.wdata !== expData[expIdx])
                reportValue(name, "wdata", expData[expIdx], c.wdata);
            expIdx++;
        end
    endtask

    task automatic checkCycle();
        if (commitMaster.valid && commitSlave.valid && expIdx + 1 < expName.size()) begin
            if (expSplit[expIdx + 1]) begin
                $display("pair %s retired both halves in one cycle though the slave depends on it",
                         expName[expIdx + 1]);
                otherErrors++;
            end
        end
        if (commitMaster.valid === 1'b1)
            checkRetire(commitMaster, 1'b0);
        if (commitSlave.valid === 1'b1)
            checkRetire(commitSlave, 1'b1);   // master first within a cycle
    endtask

    always #20 clk = ~clk;

    // cache miss on about one cycle in four
    always @(posedge clk) begin
        icacheStall <= (($random(seed) & 3) == 0);
    end

    // memory answers the cycle after instEn
    always @(posedge clk) begin
        if (instEn) begin
            inst1 <= fetchWord(pc, 1'b0);
            inst2 <= fetchWord(pc, 1'b1);
        end
    end

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        icacheStall = 1'b0;
        inst1       = '0;
        inst2       = '0;
        loadProgram();
        for (int i = 0; i < MEM_PAIRS; i++) begin
            memLo[i] = (i < progName.size()) ? progInst1[i] : '0;
            memHi[i] = (i < progName.size()) ? progInst2[i] : '0;
        end
        modelProgram();
        cycleLimit = 20 * progName.size() + 100;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        if (pc !== RESET_PC)
            reportValue("reset", "pc_o", RESET_PC, pc);
        if (instEn !== 1'b0)
            reportValue("reset", "instEn_o", 32'd0, 32'(instEn));
        if (commitMaster.valid !== 1'b0 || commitSlave.valid !== 1'b0)
            reportValue("reset", "commit valids", 32'd0, {commitMaster.valid, commitSlave.valid});
        while (expIdx < expName.size() && cycles < cycleLimit) begin
            @(negedge clk);
            cycles++;
            checkCycle();
        end
        if (expIdx < expName.size()) begin
            $display("timeout: only %0d of %0d instructions retired within %0d cycles",
                     expIdx, expName.size(), cycles);
            otherErrors++;
        end
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+test
hdl/dualIssuePkg.sv
hdl/executeLane.sv
hdl/regFile.sv
hdl/fetchUnit.sv
hdl/fetchQueue.sv
hdl/issueUnit.sv
hdl/dualIssueCore.sv
test/tbDualIssue.sv

// ==== Bender.yml ====
package:
  name: dual_issue_core

sources:
  - files:
      - hdl/dualIssuePkg.sv
      - hdl/executeLane.sv
      - hdl/regFile.sv
      - hdl/fetchUnit.sv
      - hdl/fetchQueue.sv
      - hdl/issueUnit.sv
      - hdl/dualIssueCore.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tbDualIssue.sv
